/* files.f */
+incdir+logic
logic/histoPkg.sv
logic/apbPkg.sv
logic/binRam.sv
logic/histoEngine.sv
logic/apbRegs.sv
logic/histoTop.sv
test/tbClock.sv
test/histoTop_sva.sv
test/histoTb.sv

/* logic/apbPkg.sv */
`include "histo_consts.svh"

package apbPkg;

    // master to slave
    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [`APB_AW-1:0] paddr;
        logic [`APB_DW-1:0] pwdata;
    } apbReq_t;

    // slave to master
    typedef struct packed {
        logic [`APB_DW-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apbRsp_t;

endpackage

/* logic/apbRegs.sv */
`include "histo_consts.svh"

module apbRegs import apbPkg::*, histoPkg::*; (
    input  logic     clk,
    input  logic     res,
    input  apbReq_t  apbReq,
    output apbRsp_t  apbRsp,
    output logic     start,
    output evCount_t evTarget,
    input  logic     busy,
    input  logic     runDone,
    input  logic     peakWe,
    input  pixel_t   peakPixel,
    input  peak_t    peakData
);

    peak_t              peakReg [`PIXEL_NUM];
    logic               access;
    logic               wrAccess;
    logic               hit;
    logic               peakHit;
    logic [`APB_AW-1:0] peakOfs;
    pixel_t             peakSel;

    assign access   = apbReq.psel && apbReq.penable;   // zero wait states
    assign wrAccess = access && apbReq.pwrite;

    // peak window, one word per pixel
    assign peakOfs = apbReq.paddr - `REG_PEAK0;
    assign peakHit = (apbReq.paddr >= `REG_PEAK0) && (peakOfs < 4 * `PIXEL_NUM)
                     && (peakOfs[1:0] == 2'b00);
    assign peakSel = pixel_t'(peakOfs >> 2);

    assign start = wrAccess && (apbReq.paddr == `REG_CTRL) && apbReq.pwdata[0] && !busy;

    always_comb begin
        hit           = 1'b1;
        apbRsp.prdata = '0;
        if (peakHit) begin
            apbRsp.prdata[`BIN_W-1:0]                = peakReg[peakSel].bin;
            apbRsp.prdata[`PEAK_CNT_LSB +: `COUNT_W] = peakReg[peakSel].count;
        end else begin
            case (apbReq.paddr)
                `REG_CTRL:    apbRsp.prdata = '0;   // start bit self clears
                `REG_EVCOUNT: apbRsp.prdata = `APB_DW'(evTarget);
                `REG_STATUS:  apbRsp.prdata = `APB_DW'({runDone, busy});
                default:      hit = 1'b0;
            endcase
        end
        if (!access) begin
            apbRsp.prdata = '0;
        end
        apbRsp.pready  = 1'b1;
        apbRsp.pslverr = access && !hit;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            evTarget <= '0;
            for (int p = 0; p < `PIXEL_NUM; p++) begin
                peakReg[p] <= '0;
            end
        end else begin
            if (wrAccess && apbReq.paddr == `REG_EVCOUNT) begin
                evTarget <= apbReq.pwdata[`EVCNT_W-1:0];
            end
            if (peakWe) begin
                peakReg[peakPixel] <= peakData;   // held until the next scan
            end
        end
    end

endmodule

/* logic/binRam.sv */
`include "histo_consts.svh"

module binRam import histoPkg::*; (
    input  logic     clk,
    input  logic     wrEn,
    input  ramAddr_t wrAddr,
    input  count_t   wrData,
    input  ramAddr_t rdAddr,
    output count_t   rdData
);

    count_t mem [`RAM_DEPTH];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // read port returns old data on a same-cycle write
    always_ff @(posedge clk) begin
        rdData <= mem[rdAddr];
    end

endmodule

/* logic/histoEngine.sv */
`include "histo_consts.svh"

module histoEngine import histoPkg::*; (
    input  logic     clk,
    input  logic     res,
    input  logic     start,
    input  evCount_t evTarget,
    input  logic     evValid,
    input  event_t   evData,
    output logic     evReady,
    output logic     wrEn,
    output ramAddr_t wrAddr,
    output count_t   wrData,
    output ramAddr_t rdAddr,
    input  count_t   rdData,
    output logic     busy,
    output logic     runDone,
    output logic     peakWe,
    output pixel_t   peakPixel,
    output peak_t    peakData
);

    engineState_t state;
    ramAddr_t     addrCnt;      // clear address, later scan read address
    evCount_t     evCnt;
    logic         scanTail;     // last cycle of a pixel, no read issued

    // read-modify-write pipeline
    logic     pendValid;        // event read last cycle, write due now
    ramAddr_t pendAddr;
    logic     fwdValid;         // copy of the previous accumulate write
    ramAddr_t fwdAddr;
    count_t   fwdData;

    // peak search
    logic   cmpValid;
    bin_t   cmpBin;
    count_t maxCount;
    bin_t   maxBin;

    logic     take;
    logic     lastEvent;
    logic     lastBin;
    logic     lastPixel;
    ramAddr_t evAddr;
    count_t   baseCount;
    count_t   incCount;
    logic     newMax;
    peak_t    cand;

    assign evReady   = (state == ACCUM);
    assign take      = evValid && evReady;
    assign evAddr    = {evData.pixel, evData.arrival[`TIME_W-1 -: `BIN_W]};
    assign lastEvent = (evCnt == evCount_t'(evTarget - 1'b1));
    assign lastBin   = (addrCnt[`BIN_W-1:0] == bin_t'(`BIN_NUM - 1));
    assign lastPixel = (addrCnt[`RAM_AW-1:`BIN_W] == pixel_t'(`PIXEL_NUM - 1));

    // bypass the memory when the previous write hit the same bin
    assign baseCount = (fwdValid && fwdAddr == pendAddr) ? fwdData : rdData;
    assign incCount  = (baseCount == '1) ? baseCount : count_t'(baseCount + 1'b1);

    assign wrEn   = (state == CLEAR) || pendValid;
    assign wrAddr = (state == CLEAR) ? addrCnt : pendAddr;
    assign wrData = (state == CLEAR) ? '0 : incCount;
    assign rdAddr = (state == ACCUM) ? evAddr : addrCnt;

    // bin 0 always restarts the maximum, later bins need a strictly larger count
    assign newMax     = (cmpBin == '0) || (rdData > maxCount);
    assign cand.bin   = newMax ? cmpBin : maxBin;
    assign cand.count = newMax ? rdData : maxCount;

    assign peakWe    = (state == SCAN) && scanTail;
    assign peakPixel = addrCnt[`RAM_AW-1:`BIN_W];
    assign peakData  = cand;   // includes bin 15 arriving in the tail cycle

    assign busy    = (state != IDLE) && (state != DONE);
    assign runDone = (state == DONE);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= IDLE;
            addrCnt   <= '0;
            evCnt     <= '0;
            scanTail  <= 1'b0;
            pendValid <= 1'b0;
            fwdValid  <= 1'b0;
            cmpValid  <= 1'b0;
        end else begin
            pendValid <= take;
            fwdValid  <= pendValid;
            cmpValid  <= (state == SCAN) && !scanTail;
            case (state)
                IDLE, DONE: begin
                    if (start) begin
                        state   <= CLEAR;
                        addrCnt <= '0;
                        evCnt   <= '0;
                    end
                end
                CLEAR: begin
                    addrCnt <= addrCnt + 1'b1;   // wraps back to 0 for scan
                    if (addrCnt == '1) begin
                        state <= (evTarget == '0) ? SCAN : ACCUM;
                    end
                end
                ACCUM: begin
                    if (take) begin
                        evCnt <= evCnt + 1'b1;
                        if (lastEvent) begin
                            state <= DRAIN;
                        end
                    end
                end
                DRAIN: begin
                    state <= SCAN;   // last write goes out here
                end
                SCAN: begin
                    if (scanTail) begin
                        scanTail <= 1'b0;
                        addrCnt  <= addrCnt + 1'b1;
                        if (lastPixel) begin
                            state <= DONE;
                        end
                    end else if (lastBin) begin
                        scanTail <= 1'b1;
                    end else begin
                        addrCnt <= addrCnt + 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        pendAddr <= evAddr;
        fwdAddr  <= pendAddr;
        fwdData  <= incCount;
        cmpBin   <= addrCnt[`BIN_W-1:0];
        if (cmpValid) begin
            maxCount <= cand.count;
            maxBin   <= cand.bin;
        end
    end

endmodule

/* logic/histoPkg.sv */
`include "histo_consts.svh"

package histoPkg;

    typedef logic [`PIXEL_W-1:0] pixel_t;
    typedef logic [`TIME_W-1:0]  time_t;
    typedef logic [`BIN_W-1:0]   bin_t;
    typedef logic [`COUNT_W-1:0] count_t;
    typedef logic [`RAM_AW-1:0]  ramAddr_t;    // {pixel, bin}
    typedef logic [`EVCNT_W-1:0] evCount_t;

    typedef struct packed {
        pixel_t pixel;
        time_t  arrival;
    } event_t;

    typedef struct packed {
        bin_t   bin;
        count_t count;
    } peak_t;

    typedef enum logic [2:0] {IDLE, CLEAR, ACCUM, DRAIN, SCAN, DONE} engineState_t;

endpackage

/* logic/histoTop.sv */
module histoTop import apbPkg::*, histoPkg::*; (
    input  logic    clk,
    input  logic    res,
    input  apbReq_t apbReq,
    output apbRsp_t apbRsp,
    input  logic    evValid,
    input  event_t  evData,
    output logic    evReady
);

    // control path
    logic     start;
    evCount_t evTarget;
    logic     busy;
    logic     runDone;
    logic     peakWe;
    pixel_t   peakPixel;
    peak_t    peakData;

    // bin memory ports
    logic     wrEn;
    ramAddr_t wrAddr;
    count_t   wrData;
    ramAddr_t rdAddr;
    count_t   rdData;

    apbRegs regs_i (
        .clk       (clk),
        .res       (res),
        .apbReq    (apbReq),
        .apbRsp    (apbRsp),
        .start     (start),
        .evTarget  (evTarget),
        .busy      (busy),
        .runDone   (runDone),
        .peakWe    (peakWe),
        .peakPixel (peakPixel),
        .peakData  (peakData)
    );

    histoEngine engine_i (
        .clk       (clk),
        .res       (res),
        .start     (start),
        .evTarget  (evTarget),
        .evValid   (evValid),
        .evData    (evData),
        .evReady   (evReady),
        .wrEn      (wrEn),
        .wrAddr    (wrAddr),
        .wrData    (wrData),
        .rdAddr    (rdAddr),
        .rdData    (rdData),
        .busy      (busy),
        .runDone   (runDone),
        .peakWe    (peakWe),
        .peakPixel (peakPixel),
        .peakData  (peakData)
    );

    binRam ram_i (
        .clk    (clk),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .rdAddr (rdAddr),
        .rdData (rdData)
    );

endmodule

/* logic/histo_consts.svh */
`ifndef HISTO_CONSTS_SVH
`define HISTO_CONSTS_SVH

// array geometry
`define PIXEL_NUM    4
`define PIXEL_W      2
`define BIN_NUM      16
`define BIN_W        4              // bin = top bits of arrival time
`define TIME_W       8
`define COUNT_W      8
`define EVCNT_W      16
`define RAM_AW       (`PIXEL_W + `BIN_W)
`define RAM_DEPTH    (`PIXEL_NUM * `BIN_NUM)

// APB side
`define APB_AW       8
`define APB_DW       32
`define PEAK_CNT_LSB 8              // count field position in a peak register

`define REG_CTRL     8'h00
`define REG_EVCOUNT  8'h04
`define REG_STATUS   8'h08
`define REG_PEAK0    8'h10

`endif

/* run.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module histoTb --Mdir "$buildDir" -o histoSim -f files.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$buildDir/histoSim" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -q "TESTS FAILED" "$logFile"; then
    echo "simulation reported failure"
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi
echo "simulation finished cleanly"
exit 0

/* test/histoTb.sv */
`include "histo_consts.svh"

module histoTb import apbPkg::*, histoPkg::*; ();

    localparam int PERIOD    = 40;
    localparam int DRIVE_DLY = 5;
    localparam int ROWS      = 6;
    localparam logic [`APB_AW-1:0] UNMAPPED = 8'h40;

    typedef enum logic [1:0] {RANDOM, SINGLE, TIE, SATURATE} runMode_t;

    typedef struct packed {
        evCount_t events;
        runMode_t mode;
        bin_t     hotBin;
    } runRow_t;

    // one row per run, applied in order
    runRow_t runTable [ROWS] = '{
        '{16'd200, RANDOM,   4'd0},
        '{16'd120, SINGLE,   4'd5},     // back-to-back hits on one bin
        '{16'd40,  TIE,      4'd9},
        '{16'd300, SATURATE, 4'd12},
        '{16'd0,   RANDOM,   4'd0},     // empty run, all peaks must read zero
        '{16'd64,  RANDOM,   4'd0}
    };

    logic    clk;
    logic    res;
    apbReq_t apbReq;
    apbRsp_t apbRsp;
    logic    evValid;
    event_t  evData;
    logic    evReady;

    integer  seed;
    event_t  evQ [$];
    int      hist [`PIXEL_NUM][`BIN_NUM];   // reference histogram, unsaturated

    tbClock #(.period(PERIOD)) clk_i (.clk(clk));

    histoTop dut_i (
        .clk     (clk),
        .res     (res),
        .apbReq  (apbReq),
        .apbRsp  (apbRsp),
        .evValid (evValid),
        .evData  (evData),
        .evReady (evReady)
    );

    bind histoTop histoTop_sva sva_i (
        .clk     (clk),
        .res     (res),
        .evReady (evReady),
        .wrEn    (wrEn),
        .busy    (busy),
        .runDone (runDone),
        .apbRsp  (apbRsp)
    );

    task automatic abortRun();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkPeak(input string name, input peak_t got, input peak_t exp);
        if (got !== exp) begin
            $display("Error %s: got bin 0x%h count 0x%h, expected bin 0x%h count 0x%h",
                     name, got.bin, got.count, exp.bin, exp.count);
            abortRun();
        end
    endtask

    task automatic checkStatus(input logic busyGot, input logic doneGot,
                               input logic busyExp, input logic doneExp);
        if ({busyGot, doneGot} !== {busyExp, doneExp}) begin
            $display("Error status: busy 0x%h runDone 0x%h, expected busy 0x%h runDone 0x%h",
                     busyGot, doneGot, busyExp, doneExp);
            abortRun();
        end
    endtask

    task automatic checkErr(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error pslverr (%s): got 0x%h expected 0x%h", name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkCount(input evCount_t got, input evCount_t exp);
        if (got !== exp) begin
            $display("Error evTarget: got 0x%h expected 0x%h", got, exp);
            abortRun();
        end
    endtask

    // setup phase then one access phase, sampled mid cycle
    task automatic apbXfer(input logic isWrite, input logic [`APB_AW-1:0] addr,
                           input logic [`APB_DW-1:0] wdata,
                           output logic [`APB_DW-1:0] rdata, output logic err);
        apbReq.psel    = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = isWrite;
        apbReq.paddr   = addr;
        apbReq.pwdata  = wdata;
        @(posedge clk);
        #DRIVE_DLY;
        apbReq.penable = 1'b1;
        #(PERIOD / 2 - DRIVE_DLY);
        rdata = apbRsp.prdata;
        err   = apbRsp.pslverr;
        @(posedge clk);
        #DRIVE_DLY;
        apbReq = '0;
    endtask

    task automatic apbWrite(input logic [`APB_AW-1:0] addr, input logic [`APB_DW-1:0] data);
        logic [`APB_DW-1:0] rd;
        logic               err;
        apbXfer(1'b1, addr, data, rd, err);
        checkErr($sformatf("write 0x%h", addr), err, 1'b0);
    endtask

    task automatic buildEvents(input runRow_t row);
        logic [31:0] r;
        event_t      ev;
        pixel_t      pix;
        bin_t        bin;
        for (int p = 0; p < `PIXEL_NUM; p++) begin
            for (int b = 0; b < `BIN_NUM; b++) begin
                hist[p][b] = 0;
            end
        end
        evQ.delete();
        for (int i = 0; i < int'(row.events); i++) begin
            r = $random(seed);
            case (row.mode)
                SINGLE:   pix = 2'd1;
                TIE:      pix = pixel_t'(i >> 1);     // pairs of events per pixel
                SATURATE: pix = 2'd3;
                default:  pix = r[1:0];
            endcase
            case (row.mode)
                RANDOM:  bin = r[7:4];
                TIE:     bin = i[0] ? row.hotBin : bin_t'(row.hotBin + 4);
                default: bin = row.hotBin;
            endcase
            ev.pixel   = pix;
            ev.arrival = {bin, r[11:8]};
            evQ.push_back(ev);
            hist[pix][bin]++;
        end
    endtask

    // lowest bin holding the largest saturated count
    function automatic peak_t expectedPeak(input int p);
        peak_t best;
        int    sat;
        best = '0;
        for (int b = 0; b < `BIN_NUM; b++) begin
            sat = (hist[p][b] > (1 << `COUNT_W) - 1) ? (1 << `COUNT_W) - 1 : hist[p][b];
            if (b == 0 || sat > int'(best.count)) begin
                best.bin   = bin_t'(b);
                best.count = count_t'(sat);
            end
        end
        return best;
    endfunction

    task automatic driveEvents(input logic gaps, input int first, input int last);
        int   idx;
        logic taken;
        idx = first;
        while (idx < last) begin
            evData  = evQ[idx];
            evValid = !(gaps && (($random(seed) & 3) == 0));   // source stalls now and then
            #(PERIOD / 2 - DRIVE_DLY);
            taken = evValid && evReady;
            @(posedge clk);
            #DRIVE_DLY;
            if (taken) begin
                idx++;
            end
        end
        evValid = 1'b0;
    endtask

    task automatic runOne(input runRow_t row);
        logic [`APB_DW-1:0] rd;
        logic               err;
        peak_t              got;
        int                 half;
        buildEvents(row);
        half = evQ.size() / 2;
        apbWrite(`REG_EVCOUNT, `APB_DW'(row.events));
        apbXfer(1'b0, `REG_EVCOUNT, '0, rd, err);
        checkErr("event count", err, 1'b0);
        checkCount(evCount_t'(rd), row.events);
        apbWrite(`REG_CTRL, 32'h1);
        apbXfer(1'b0, `REG_STATUS, '0, rd, err);
        checkErr("status", err, 1'b0);
        checkStatus(rd[0], rd[1], 1'b1, 1'b0);
        apbXfer(1'b1, UNMAPPED, '1, rd, err);
        checkErr("unmapped write", err, 1'b1);
        apbXfer(1'b0, UNMAPPED, '0, rd, err);
        checkErr("unmapped read", err, 1'b1);
        driveEvents(row.mode == RANDOM, 0, half);
        apbWrite(`REG_CTRL, 32'h1);     // mid accumulate, must not restart the run
        driveEvents(row.mode == RANDOM, half, evQ.size());
        do begin
            apbXfer(1'b0, `REG_STATUS, '0, rd, err);
        end while (rd[0]);
        checkStatus(rd[0], rd[1], 1'b0, 1'b1);
        for (int p = 0; p < `PIXEL_NUM; p++) begin
            apbXfer(1'b0, `REG_PEAK0 + 8'(4 * p), '0, rd, err);
            checkErr($sformatf("peak%0d", p), err, 1'b0);
            got.bin   = rd[`BIN_W-1:0];
            got.count = rd[`PEAK_CNT_LSB +: `COUNT_W];
            checkPeak($sformatf("peak%0d", p), got, expectedPeak(p));
        end
    endtask

    initial begin : watchdog
        int limitCycles;
        limitCycles = 0;
        for (int r = 0; r < ROWS; r++) begin
            limitCycles += int'(runTable[r].events) + 200;
        end
        #(limitCycles * PERIOD);
        $display("timeout: run did not finish within %0d clock cycles", limitCycles);
        abortRun();
    end

    initial begin : stimulus
        seed    = 63110;
        res     = 1'b0;
        apbReq  = '0;
        evValid = 1'b0;
        evData  = '0;
        repeat (8) @(posedge clk);
        #DRIVE_DLY;
        res = 1'b1;
        for (int r = 0; r < ROWS; r++) begin
            runOne(runTable[r]);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* test/histoTop_sva.sv */
module histoTop_sva import apbPkg::*; (
    input logic    clk,
    input logic    res,
    input logic    evReady,
    input logic    wrEn,
    input logic    busy,
    input logic    runDone,
    input apbRsp_t apbRsp
);

    // events accepted only once all 64 bins are cleared
    readyAfterClear: assert property (@(posedge clk) disable iff (!res)
        $rose(evReady) |-> $past(busy, 64) && !$past(busy, 65))
        else $error("evReady rose before the clear phase was over");

    noIdleWrite: assert property (@(posedge clk) disable iff (!res)
        !busy |-> !wrEn)
        else $error("bin memory written while not busy");

    // a run only ends by reaching done
    busyEndsInDone: assert property (@(posedge clk) disable iff (!res)
        $fell(busy) |-> runDone)
        else $error("busy fell without runDone");

    // zero wait state slave
    alwaysReady: assert property (@(posedge clk) disable iff (!res)
        apbRsp.pready)
        else $error("pready dropped");

    // outputs held quiet while reset is applied
    resetValues: assert property (@(posedge clk)
        !res |-> !evReady && !wrEn && !busy && !runDone
                 && !apbRsp.pslverr && (apbRsp.prdata == '0))
        else $error("output not at its reset value");

endmodule

/* test/tbClock.sv */
module tbClock #(
    parameter int period = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

endmodule
